// ==== src/pss_pkg.sv ====
`default_nettype none

package pss_pkg;

  // --------------------
  // Bus and block widths
  // --------------------
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int GPIO_W = 8;
  localparam int PIT_W  = 16;
  localparam int IRQ_N  = 2;

  // Slot field sits in the top address bits
  localparam int SLOT_W = 2;
  localparam int OFF_W  = ADDR_W - SLOT_W;

  // --------------------
  // Address map
  // --------------------
  localparam logic [SLOT_W-1:0] SLOT_GPIO = 2'd0;
  localparam logic [SLOT_W-1:0] SLOT_PIT  = 2'd1;
  localparam logic [SLOT_W-1:0] SLOT_IRQ  = 2'd2;
  // Slot 3 left unmapped, answered with an error

  // GPIO register offsets
  localparam logic [OFF_W-1:0] GPIO_DOUT    = 6'h00;
  localparam logic [OFF_W-1:0] GPIO_OE      = 6'h04;
  localparam logic [OFF_W-1:0] GPIO_DIN     = 6'h08;
  localparam logic [OFF_W-1:0] GPIO_RISE_EN = 6'h0C;

  // Timer register offsets
  localparam logic [OFF_W-1:0] PIT_LOAD  = 6'h00;
  localparam logic [OFF_W-1:0] PIT_CTRL  = 6'h04;
  localparam logic [OFF_W-1:0] PIT_COUNT = 6'h08;

  // Timer CTRL bit positions
  localparam int PIT_CTRL_EN     = 0;
  localparam int PIT_CTRL_RELOAD = 1;

  // Interrupt combiner register offsets
  localparam logic [OFF_W-1:0] IRQ_STATUS = 6'h00;
  localparam logic [OFF_W-1:0] IRQ_MASK   = 6'h04;

  // Interrupt source bit positions
  localparam int IRQ_SRC_GPIO = 0;
  localparam int IRQ_SRC_PIT  = 1;

  // --------------------
  // APB request and response
  // --------------------
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // One bit per interrupt source
  typedef logic [IRQ_N-1:0] irq_vec_t;

endpackage

`default_nettype wire

// ==== src/apb_slot_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_slot_mux (
  input  logic              HCLK,
  input  logic              reset_i,
  input  pss_pkg::apb_req_t req_i,
  output pss_pkg::apb_rsp_t rsp_o,
  output pss_pkg::apb_req_t gpio_req_o,
  input  pss_pkg::apb_rsp_t gpio_rsp_i,
  output pss_pkg::apb_req_t pit_req_o,
  input  pss_pkg::apb_rsp_t pit_rsp_i,
  output pss_pkg::apb_req_t irq_req_o,
  input  pss_pkg::apb_rsp_t irq_rsp_i
);
  import pss_pkg::*;

  logic [SLOT_W-1:0] addr_slot;
  logic [SLOT_W-1:0] slot_q;
  logic [SLOT_W-1:0] slot_sel;
  logic              setup;
  logic              access;

  // Slot number from the top address bits
  assign addr_slot = req_i.paddr[ADDR_W-1 -: SLOT_W];

  // APB phases
  assign setup  = req_i.psel & ~req_i.penable;
  assign access = req_i.psel & req_i.penable;

  // --------------------
  // Slot capture
  // --------------------
  // Decoded in setup, held for the access cycle
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      slot_q <= SLOT_GPIO;
    end else if (setup) begin
      slot_q <= addr_slot;
    end
  end

  // Live decode in setup, captured slot in access
  assign slot_sel = req_i.penable ? slot_q : addr_slot;

  // --------------------
  // Request fan-out
  // --------------------
  always_comb begin
    gpio_req_o = req_i;
    pit_req_o  = req_i;
    irq_req_o  = req_i;
    // Only the matching slave sees psel
    gpio_req_o.psel = req_i.psel & (slot_sel == SLOT_GPIO);
    pit_req_o.psel  = req_i.psel & (slot_sel == SLOT_PIT);
    irq_req_o.psel  = req_i.psel & (slot_sel == SLOT_IRQ);
  end

  // --------------------
  // Response select
  // --------------------
  always_comb begin
    // Idle bus reads as ready with no data
    rsp_o = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};
    if (access) begin
      case (slot_sel)
        SLOT_GPIO: rsp_o = gpio_rsp_i;
        SLOT_PIT:  rsp_o = pit_rsp_i;
        SLOT_IRQ:  rsp_o = irq_rsp_i;
        // Unmapped slot, zero data with error
        default:   rsp_o.pslverr = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/gpio_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
  input  logic                      HCLK,
  input  logic                      reset_i,
  input  pss_pkg::apb_req_t         req_i,
  output pss_pkg::apb_rsp_t         rsp_o,
  input  logic [pss_pkg::GPIO_W-1:0] gpio_i,
  output logic [pss_pkg::GPIO_W-1:0] gpio_o,
  output logic [pss_pkg::GPIO_W-1:0] gpio_oe_o,
  output logic                      irq_o
);
  import pss_pkg::*;

  logic [OFF_W-1:0]  offset;
  logic              wr_en;
  logic              rd_en;
  logic [GPIO_W-1:0] dout_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] rise_en_q;
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] prev_q;
  logic [GPIO_W-1:0] rise;
  logic [DATA_W-1:0] rdata;

  // Offset within the slot, psel already decoded
  assign offset = req_i.paddr[OFF_W-1:0];
  assign wr_en  = req_i.psel & req_i.penable & req_i.pwrite;
  assign rd_en  = req_i.psel & req_i.penable & ~req_i.pwrite;

  // --------------------
  // Control registers
  // --------------------
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      dout_q    <= '0;
      oe_q      <= '0;
      rise_en_q <= '0;
    end else if (wr_en) begin
      case (offset)
        GPIO_DOUT:    dout_q    <= req_i.pwdata[GPIO_W-1:0];
        GPIO_OE:      oe_q      <= req_i.pwdata[GPIO_W-1:0];
        GPIO_RISE_EN: rise_en_q <= req_i.pwdata[GPIO_W-1:0];
        // DIN is read-only, other offsets ignored
        default: ;
      endcase
    end
  end

  // --------------------
  // Input path
  // --------------------
  // Two flop synchronizer, then one more stage for edge detect
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // Low to high on an enabled pin
  assign rise  = sync2_q & ~prev_q & rise_en_q;
  assign irq_o = |rise;

  // Pins
  assign gpio_o    = dout_q;
  assign gpio_oe_o = oe_q;

  // --------------------
  // Read path
  // --------------------
  always_comb begin
    rdata = '0;
    if (rd_en) begin
      case (offset)
        GPIO_DOUT:    rdata = DATA_W'(dout_q);
        GPIO_OE:      rdata = DATA_W'(oe_q);
        GPIO_DIN:     rdata = DATA_W'(sync2_q);
        GPIO_RISE_EN: rdata = DATA_W'(rise_en_q);
        default:      rdata = '0;
      endcase
    end
  end

  // No wait states, no errors
  assign rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};

endmodule

`default_nettype wire

// ==== src/pit_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pit_timer (
  input  logic              HCLK,
  input  logic              reset_i,
  input  pss_pkg::apb_req_t req_i,
  output pss_pkg::apb_rsp_t rsp_o,
  output logic              irq_o
);
  import pss_pkg::*;

  logic [OFF_W-1:0]  offset;
  logic              wr_en;
  logic              rd_en;
  logic              wr_load;
  logic              wr_ctrl;
  logic [PIT_W-1:0]  load_q;
  logic [PIT_W-1:0]  count_q;
  logic              en_q;
  logic              reload_q;
  logic              underflow;
  logic [DATA_W-1:0] rdata;

  assign offset  = req_i.paddr[OFF_W-1:0];
  assign wr_en   = req_i.psel & req_i.penable & req_i.pwrite;
  assign rd_en   = req_i.psel & req_i.penable & ~req_i.pwrite;
  assign wr_load = wr_en & (offset == PIT_LOAD);
  assign wr_ctrl = wr_en & (offset == PIT_CTRL);

  // Enabled cycle with count at zero
  assign underflow = en_q & (count_q == '0);
  assign irq_o     = underflow;

  // --------------------
  // Load and control
  // --------------------
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      load_q   <= '0;
      reload_q <= 1'b0;
    end else begin
      if (wr_load) begin
        load_q <= req_i.pwdata[PIT_W-1:0];
      end
      if (wr_ctrl) begin
        reload_q <= req_i.pwdata[PIT_CTRL_RELOAD];
      end
    end
  end

  // Enable, cleared by a one-shot underflow
  // a CTRL write in the same cycle wins
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      en_q <= 1'b0;
    end else if (wr_ctrl) begin
      en_q <= req_i.pwdata[PIT_CTRL_EN];
    end else if (underflow && !reload_q) begin
      en_q <= 1'b0;
    end
  end

  // --------------------
  // Down-counter
  // --------------------
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (wr_load) begin
      // LOAD write restarts the count
      count_q <= req_i.pwdata[PIT_W-1:0];
    end else if (underflow) begin
      // Reload on underflow, one-shot holds at zero
      if (reload_q) begin
        count_q <= load_q;
      end
    end else if (en_q) begin
      count_q <= count_q - 1'b1;
    end
  end

  // --------------------
  // Read path
  // --------------------
  always_comb begin
    rdata = '0;
    if (rd_en) begin
      case (offset)
        PIT_LOAD:  rdata = DATA_W'(load_q);
        PIT_CTRL:  rdata = DATA_W'({reload_q, en_q});
        PIT_COUNT: rdata = DATA_W'(count_q);
        default:   rdata = '0;
      endcase
    end
  end

  assign rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};

endmodule

`default_nettype wire

// ==== src/irq_combiner.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_combiner (
  input  logic              HCLK,
  input  logic              reset_i,
  input  pss_pkg::apb_req_t req_i,
  output pss_pkg::apb_rsp_t rsp_o,
  input  pss_pkg::irq_vec_t irq_pulse_i,
  output logic              irq_o
);
  import pss_pkg::*;

  logic [OFF_W-1:0]  offset;
  logic              wr_en;
  logic              rd_en;
  irq_vec_t          clr;
  irq_vec_t          status_q;
  irq_vec_t          mask_q;
  logic [DATA_W-1:0] rdata;

  assign offset = req_i.paddr[OFF_W-1:0];
  assign wr_en  = req_i.psel & req_i.penable & req_i.pwrite;
  assign rd_en  = req_i.psel & req_i.penable & ~req_i.pwrite;

  // Write-one-to-clear bits for STATUS
  assign clr = (wr_en && offset == IRQ_STATUS) ? req_i.pwdata[IRQ_N-1:0] : '0;

  // --------------------
  // Status and mask
  // --------------------
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      status_q <= '0;
      mask_q   <= '0;
    end else begin
      // New pulse beats a clear in the same cycle
      status_q <= (status_q & ~clr) | irq_pulse_i;
      if (wr_en && offset == IRQ_MASK) begin
        mask_q <= req_i.pwdata[IRQ_N-1:0];
      end
    end
  end

  // Any unmasked pending source
  assign irq_o = |(status_q & mask_q);

  // --------------------
  // Read path
  // --------------------
  always_comb begin
    rdata = '0;
    if (rd_en) begin
      case (offset)
        IRQ_STATUS: rdata = DATA_W'(status_q);
        IRQ_MASK:   rdata = DATA_W'(mask_q);
        default:    rdata = '0;
      endcase
    end
  end

  assign rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};

endmodule

`default_nettype wire

// ==== src/pss_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pss_top (
  input  logic                       HCLK,
  input  logic                       reset_i,
  input  pss_pkg::apb_req_t          apb_req_i,
  output pss_pkg::apb_rsp_t          apb_rsp_o,
  input  logic [pss_pkg::GPIO_W-1:0] gpio_i,
  output logic [pss_pkg::GPIO_W-1:0] gpio_o,
  output logic [pss_pkg::GPIO_W-1:0] gpio_oe_o,
  output logic                       irq_o
);
  import pss_pkg::*;

  // Per-slave APB buses
  apb_req_t gpio_req;
  apb_rsp_t gpio_rsp;
  apb_req_t pit_req;
  apb_rsp_t pit_rsp;
  apb_req_t irq_req;
  apb_rsp_t irq_rsp;

  // Interrupt pulses
  logic     gpio_irq;
  logic     pit_irq;
  irq_vec_t irq_pulse;

  // --------------------
  // APB slot decode
  // --------------------
  apb_slot_mux apb_slot_mux_i (
    .HCLK       (HCLK),
    .reset_i    (reset_i),
    .req_i      (apb_req_i),
    .rsp_o      (apb_rsp_o),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp),
    .pit_req_o  (pit_req),
    .pit_rsp_i  (pit_rsp),
    .irq_req_o  (irq_req),
    .irq_rsp_i  (irq_rsp)
  );

  // --------------------
  // Slaves
  // --------------------
  gpio_port gpio_port_i (
    .HCLK      (HCLK),
    .reset_i   (reset_i),
    .req_i     (gpio_req),
    .rsp_o     (gpio_rsp),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .irq_o     (gpio_irq)
  );

  pit_timer pit_timer_i (
    .HCLK    (HCLK),
    .reset_i (reset_i),
    .req_i   (pit_req),
    .rsp_o   (pit_rsp),
    .irq_o   (pit_irq)
  );

  // Bit 0 GPIO, bit 1 timer
  always_comb begin
    irq_pulse               = '0;
    irq_pulse[IRQ_SRC_GPIO] = gpio_irq;
    irq_pulse[IRQ_SRC_PIT]  = pit_irq;
  end

  irq_combiner irq_combiner_i (
    .HCLK        (HCLK),
    .reset_i     (reset_i),
    .req_i       (irq_req),
    .rsp_o       (irq_rsp),
    .irq_pulse_i (irq_pulse),
    .irq_o       (irq_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_pss_checks.svh ====
`ifndef TB_PSS_CHECKS_SVH
`define TB_PSS_CHECKS_SVH

// --------------------
// Compare tasks
// --------------------

// APB response, data, ready and error flag
task automatic check_rsp(input string name, input apb_rsp_t exp_rsp, input apb_rsp_t act_rsp);
  if (act_rsp.prdata !== exp_rsp.prdata) begin
    $display("[FAIL] t=%0t %s.prdata expected 0x%08h actual 0x%08h",
             $time, name, exp_rsp.prdata, act_rsp.prdata);
    err_count++;
  end
  if (act_rsp.pready !== exp_rsp.pready) begin
    $display("[FAIL] t=%0t %s.pready expected %0b actual %0b",
             $time, name, exp_rsp.pready, act_rsp.pready);
    err_count++;
  end
  if (act_rsp.pslverr !== exp_rsp.pslverr) begin
    $display("[FAIL] t=%0t %s.pslverr expected %0b actual %0b",
             $time, name, exp_rsp.pslverr, act_rsp.pslverr);
    err_count++;
  end
endtask

// Pin outputs, sampled mid-cycle
task automatic check_pins(input logic [GPIO_W-1:0] exp_out, input logic [GPIO_W-1:0] exp_oe);
  @(negedge HCLK);
  if (gpio_out !== exp_out) begin
    $display("[FAIL] t=%0t gpio_o expected 0x%02h actual 0x%02h", $time, exp_out, gpio_out);
    err_count++;
  end
  if (gpio_oe !== exp_oe) begin
    $display("[FAIL] t=%0t gpio_oe_o expected 0x%02h actual 0x%02h", $time, exp_oe, gpio_oe);
    err_count++;
  end
endtask

// Combined interrupt line
task automatic check_irq(input logic exp_irq);
  @(negedge HCLK);
  if (irq !== exp_irq) begin
    $display("[FAIL] t=%0t irq_o expected %0b actual %0b", $time, exp_irq, irq);
    err_count++;
  end
endtask

`endif

// ==== testbench/tb_pss_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pss_top;
  import pss_pkg::*;

  localparam int BUS_TIMEOUT   = 16;
  localparam int POLL_TIMEOUT  = 64;
  localparam int IRQ_TIMEOUT   = 64;
  localparam int DRAIN_TIMEOUT = 8;

  logic              HCLK;
  logic              reset;
  apb_req_t          apb_req;
  apb_rsp_t          apb_rsp;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic              irq;

  int err_count     = 0;
  int test_count    = 0;
  int test_fail     = 0;
  int test_err_base = 0;
  int seed          = 32'h3d229c08;

  // Register model
  logic [GPIO_W-1:0] m_dout;
  logic [GPIO_W-1:0] m_oe;
  logic [GPIO_W-1:0] m_rise_en;
  logic [GPIO_W-1:0] m_din;
  logic [PIT_W-1:0]  m_load;
  logic [PIT_W-1:0]  m_count;
  logic [1:0]        m_ctrl;
  irq_vec_t          m_status;
  irq_vec_t          m_mask;

  // Pending reads for the compare process
  apb_rsp_t          exp_q[$];
  apb_rsp_t          act_q[$];
  logic [ADDR_W-1:0] addr_q[$];

  `include "tb_pss_checks.svh"

  initial begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;
  end

  pss_top pss_top_i (
    .HCLK      (HCLK),
    .reset_i   (reset),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe_o (gpio_oe),
    .irq_o     (irq)
  );

  // --------------------
  // Reference model
  // --------------------
  function automatic apb_rsp_t ref_read(input logic [ADDR_W-1:0] addr);
    apb_rsp_t         r;
    logic [OFF_W-1:0] off;
    r   = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};
    off = addr[OFF_W-1:0];
    case (addr[ADDR_W-1 -: SLOT_W])
      SLOT_GPIO: begin
        if (off == GPIO_DOUT)    r.prdata = {24'h0, m_dout};
        if (off == GPIO_OE)      r.prdata = {24'h0, m_oe};
        if (off == GPIO_DIN)     r.prdata = {24'h0, m_din};
        if (off == GPIO_RISE_EN) r.prdata = {24'h0, m_rise_en};
      end
      SLOT_PIT: begin
        if (off == PIT_LOAD)  r.prdata = {16'h0, m_load};
        if (off == PIT_CTRL)  r.prdata = {30'h0, m_ctrl};
        if (off == PIT_COUNT) r.prdata = {16'h0, m_count};
      end
      SLOT_IRQ: begin
        if (off == IRQ_STATUS) r.prdata = {30'h0, m_status};
        if (off == IRQ_MASK)   r.prdata = {30'h0, m_mask};
      end
      // Unmapped, error with zero data
      default: r.pslverr = 1'b1;
    endcase
    return r;
  endfunction

  // Read-only registers and slot 3 leave the model untouched
  function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] data);
    logic [OFF_W-1:0] off;
    off = addr[OFF_W-1:0];
    case (addr[ADDR_W-1 -: SLOT_W])
      SLOT_GPIO: begin
        if (off == GPIO_DOUT)    m_dout    = data[GPIO_W-1:0];
        if (off == GPIO_OE)      m_oe      = data[GPIO_W-1:0];
        if (off == GPIO_RISE_EN) m_rise_en = data[GPIO_W-1:0];
      end
      SLOT_PIT: begin
        if (off == PIT_LOAD) begin
          m_load  = data[PIT_W-1:0];
          m_count = data[PIT_W-1:0];
        end
        if (off == PIT_CTRL) m_ctrl = data[1:0];
      end
      SLOT_IRQ: begin
        // STATUS is write-one-to-clear
        if (off == IRQ_STATUS) m_status = m_status & ~data[IRQ_N-1:0];
        if (off == IRQ_MASK)   m_mask   = data[IRQ_N-1:0];
      end
      default: ;
    endcase
  endfunction

  // --------------------
  // APB driver
  // --------------------
  task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, output apb_rsp_t rsp);
    int waited;
    waited = 0;
    @(posedge HCLK);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
    @(posedge HCLK);
    apb_req.penable <= 1'b1;
    // Access phase, sample mid-cycle until ready
    @(negedge HCLK);
    while (apb_rsp.pready !== 1'b1 && waited < BUS_TIMEOUT) begin
      @(negedge HCLK);
      waited++;
    end
    if (apb_rsp.pready !== 1'b1) begin
      $display("ERROR: t=%0t no pready for the transfer to 0x%02h", $time, addr);
      err_count++;
    end
    rsp = apb_rsp;
    @(posedge HCLK);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    apb_rsp_t rsp;
    apb_xfer(1'b1, addr, data, rsp);
    model_write(addr, data);
  endtask

  // Expected value taken when the read completes
  task automatic apb_read(input logic [ADDR_W-1:0] addr);
    apb_rsp_t rsp;
    apb_xfer(1'b0, addr, '0, rsp);
    exp_q.push_back(ref_read(addr));
    act_q.push_back(rsp);
    addr_q.push_back(addr);
  endtask

  // Unchecked reads until the masked value shows up
  task automatic poll_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] mask,
                          input logic [DATA_W-1:0] value, input string what);
    apb_rsp_t rsp;
    int       tries;
    tries = 0;
    apb_xfer(1'b0, addr, '0, rsp);
    while ((rsp.prdata & mask) !== value && tries < POLL_TIMEOUT) begin
      apb_xfer(1'b0, addr, '0, rsp);
      tries++;
    end
    if ((rsp.prdata & mask) !== value) begin
      $display("ERROR: t=%0t timed out waiting for %s", $time, what);
      err_count++;
    end
  endtask

  task automatic wait_irq(input string what);
    int cycles;
    cycles = 0;
    @(negedge HCLK);
    while (irq !== 1'b1 && cycles < IRQ_TIMEOUT) begin
      @(negedge HCLK);
      cycles++;
    end
    if (irq !== 1'b1) begin
      $display("ERROR: t=%0t timed out waiting for %s", $time, what);
      err_count++;
    end
  endtask

  // DIN follows only after the synchronizer settles
  task automatic drive_pins(input logic [GPIO_W-1:0] val);
    @(posedge HCLK);
    gpio_in <= val;
    m_din = val;
  endtask

  // Enough for synchronizer plus edge stage
  task automatic settle();
    repeat (8) @(posedge HCLK);
  endtask

  task automatic read_all_regs();
    apb_read({SLOT_GPIO, GPIO_DOUT});
    apb_read({SLOT_GPIO, GPIO_OE});
    apb_read({SLOT_GPIO, GPIO_DIN});
    apb_read({SLOT_GPIO, GPIO_RISE_EN});
    apb_read({SLOT_PIT, PIT_LOAD});
    apb_read({SLOT_PIT, PIT_CTRL});
    apb_read({SLOT_PIT, PIT_COUNT});
    apb_read({SLOT_IRQ, IRQ_STATUS});
    apb_read({SLOT_IRQ, IRQ_MASK});
    check_pins(m_dout, m_oe);
    check_irq(|(m_status & m_mask));
  endtask

  // --------------------
  // Compare process
  // --------------------
  always @(posedge HCLK) begin : compare_reads
    apb_rsp_t          exp_rsp;
    apb_rsp_t          act_rsp;
    logic [ADDR_W-1:0] addr;
    while (addr_q.size() != 0) begin
      exp_rsp = exp_q.pop_front();
      act_rsp = act_q.pop_front();
      addr    = addr_q.pop_front();
      check_rsp($sformatf("rsp[0x%02h]", addr), exp_rsp, act_rsp);
    end
  end

  task automatic finish_test(input string name);
    int cycles;
    int errs;
    cycles = 0;
    while (addr_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      @(posedge HCLK);
      cycles++;
    end
    if (addr_q.size() != 0) begin
      $display("ERROR: t=%0t compare process left reads unchecked", $time);
      err_count++;
    end
    errs = err_count - test_err_base;
    test_count++;
    if (errs == 0) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      test_fail++;
      $display("test %0d %s: %0d errors", test_count, name, errs);
    end
    test_err_base = err_count;
  endtask

  // --------------------
  // Tests
  // --------------------
  initial begin : main
    logic [DATA_W-1:0] rnd;
    logic [ADDR_W-1:0] addr;
    apb_rsp_t          rsp;
    apb_req  <= '0;
    gpio_in  <= '0;
    reset    <= 1'b1;
    m_dout    = '0;
    m_oe      = '0;
    m_rise_en = '0;
    m_din     = '0;
    m_load    = '0;
    m_count   = '0;
    m_ctrl    = '0;
    m_status  = '0;
    m_mask    = '0;
    repeat (2) @(posedge HCLK);
    reset <= 1'b0;

    // Reset values, then random writes incl. read-only offsets
    read_all_regs();
    rnd = $random(seed);
    apb_write({SLOT_GPIO, GPIO_DOUT}, rnd);
    rnd = $random(seed);
    apb_write({SLOT_GPIO, GPIO_OE}, rnd);
    rnd = $random(seed);
    apb_write({SLOT_GPIO, GPIO_RISE_EN}, rnd);
    rnd = $random(seed);
    apb_write({SLOT_GPIO, GPIO_DIN}, rnd);
    rnd = $random(seed);
    apb_write({SLOT_PIT, PIT_LOAD}, rnd);
    rnd = $random(seed);
    apb_write({SLOT_PIT, PIT_COUNT}, rnd);
    rnd = $random(seed);
    apb_write({SLOT_IRQ, IRQ_MASK}, rnd);
    read_all_regs();
    apb_read({SLOT_GPIO, 6'h10});
    finish_test("readback");

    apb_write({SLOT_GPIO, GPIO_RISE_EN}, '0);
    apb_write({SLOT_IRQ, IRQ_MASK}, '0);
    rnd = $random(seed);
    drive_pins(rnd[GPIO_W-1:0]);
    poll_reg({SLOT_GPIO, GPIO_DIN}, 32'hFF, {24'h0, rnd[GPIO_W-1:0]}, "DIN to follow gpio_i");
    apb_read({SLOT_GPIO, GPIO_DIN});
    drive_pins('0);
    poll_reg({SLOT_GPIO, GPIO_DIN}, 32'hFF, 32'h0, "DIN to return to zero");
    finish_test("input_path");

    // Rising edge on pin 3
    apb_write({SLOT_GPIO, GPIO_RISE_EN}, 32'h08);
    apb_write({SLOT_IRQ, IRQ_MASK}, 32'h01);
    drive_pins(8'h08);
    wait_irq("irq_o after rising edge on pin 3");
    m_status[IRQ_SRC_GPIO] = 1'b1;
    apb_read({SLOT_IRQ, IRQ_STATUS});
    check_irq(1'b1);
    apb_write({SLOT_IRQ, IRQ_STATUS}, 32'h1);
    apb_read({SLOT_IRQ, IRQ_STATUS});
    check_irq(1'b0);
    // Falling edge, then a pin without RISE_EN
    drive_pins(8'h00);
    settle();
    drive_pins(8'h20);
    settle();
    apb_read({SLOT_IRQ, IRQ_STATUS});
    check_irq(1'b0);
    apb_write({SLOT_GPIO, GPIO_RISE_EN}, '0);
    apb_write({SLOT_IRQ, IRQ_MASK}, '0);
    drive_pins(8'h00);
    settle();
    finish_test("gpio_irq");

    // One-shot, masked
    apb_write({SLOT_PIT, PIT_LOAD}, 32'd20);
    apb_write({SLOT_PIT, PIT_CTRL}, 32'h1);
    poll_reg({SLOT_IRQ, IRQ_STATUS}, 32'h2, 32'h2, "timer one-shot interrupt");
    m_status[IRQ_SRC_PIT] = 1'b1;
    m_ctrl  = 2'b00;
    m_count = '0;
    apb_read({SLOT_IRQ, IRQ_STATUS});
    apb_read({SLOT_PIT, PIT_CTRL});
    apb_read({SLOT_PIT, PIT_COUNT});
    check_irq(1'b0);
    apb_write({SLOT_IRQ, IRQ_STATUS}, 32'h2);
    finish_test("timer_oneshot");

    // Periodic mode
    apb_write({SLOT_PIT, PIT_LOAD}, 32'd10);
    apb_write({SLOT_PIT, PIT_CTRL}, 32'h3);
    poll_reg({SLOT_IRQ, IRQ_STATUS}, 32'h2, 32'h2, "first reload interrupt");
    apb_write({SLOT_IRQ, IRQ_STATUS}, 32'h2);
    poll_reg({SLOT_IRQ, IRQ_STATUS}, 32'h2, 32'h2, "second reload interrupt");
    apb_read({SLOT_PIT, PIT_CTRL});
    apb_write({SLOT_PIT, PIT_CTRL}, 32'h0);
    apb_write({SLOT_IRQ, IRQ_STATUS}, 32'h2);
    finish_test("timer_reload");

    // Stopped timer, so LOAD also fixes COUNT
    rnd = $random(seed);
    apb_write({SLOT_PIT, PIT_LOAD}, rnd);
    for (int i = 0; i < 4; i++) begin
      rnd  = $random(seed);
      addr = {2'b11, 6'(4 * i)};
      apb_xfer(1'b1, addr, rnd, rsp);
      check_rsp($sformatf("write_rsp[0x%02h]", addr), ref_read(addr), rsp);
      model_write(addr, rnd);
    end
    apb_read(8'hC0);
    apb_read(8'hC8);
    read_all_regs();
    finish_test("unmapped");

    $display("Summary: %0d tests, %0d with errors, %0d errors in total",
             test_count, test_fail, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+testbench
src/pss_pkg.sv
src/apb_slot_mux.sv
src/gpio_port.sv
src/pit_timer.sv
src/irq_combiner.sv
src/pss_top.sv
testbench/tb_pss_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pss_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= TEST OK

SRCS := $(shell grep -v '^+' $(FILELIST)) testbench/tb_pss_checks.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
